// ==== flist.f ====
+incdir+src
src/sfp_pkg.sv
src/wb_if.sv
src/sfp_wb_router.sv
src/sfp_csr_regs.sv
src/drp_bridge.sv
src/sfp_ctrl_top.sv
verif/sfp_ctrl_props.sv
verif/sfp_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := sfp_ctrl_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/sfp_ctrl_tb.sv ====
`timescale 1ns/1ps

module sfp_ctrl_tb;

    logic        wb_clk_i = 1'b0;
    logic        reset_i = 1'b1;
    logic        wb_cyc_i = 1'b0, wb_stb_i = 1'b0, wb_we_i = 1'b0;
    logic [13:0] wb_adr_i = '0;
    logic [31:0] wb_dat_i = '0;
    logic [3:0]  wb_sel_i = '0;
    logic        qpll_lock_i = 1'b0;
    logic [1:0]  block_lock_i = '0, high_ber_i = '0, drp_rdy_i = '0;
    logic [31:0] dmonitor_i = '0, drp_do_i = '0;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o, wb_err_o, gt_reset_o, drp_we_o;
    logic [1:0]  eye_reset_o, drp_en_o;
    logic [5:0]  loopback_o;
    logic [9:0]  drp_addr_o;
    logic [15:0] drp_di_o;

    // last DRP access seen by the lane model
    logic [15:0] drp_mem [2][1024];
    logic        drp_silent = 1'b0;
    logic        mdl_lane;
    logic [9:0]  mdl_addr;
    int          seed = 7145;

    // expected control registers
    logic        exp_gt = 1'b0;
    logic [1:0]  exp_eye = '0;
    logic [5:0]  exp_lb = '0;
    logic [31:0] rd;
    int          errors = 0, test_errors = 0, tests = 0, failed = 0;

    sfp_ctrl_top sfp_ctrl_top_i (.*);

    always #2 wb_clk_i = ~wb_clk_i;

    // DRP responder answers the pulsed lane after 1 to 8 cycles
    always begin
        @(posedge wb_clk_i);
        #1;
        if (!reset_i && !drp_silent && drp_en_o != 2'b00) begin
            mdl_lane = drp_en_o[1];
            mdl_addr = drp_addr_o;
            if (drp_we_o) begin
                drp_mem[mdl_lane][mdl_addr] = drp_di_o;
            end
            repeat (1 + ($unsigned($random(seed)) % 8)) @(posedge wb_clk_i);
            #1;
            drp_do_i[mdl_lane*16 +: 16] = drp_mem[mdl_lane][mdl_addr];
            drp_rdy_i[mdl_lane] = 1'b1;
            @(posedge wb_clk_i);
            #1;
            drp_rdy_i = 2'b00;
        end
    end

    function automatic logic [15:0] fill_value(input logic lane, input logic [9:0] addr);
        return {lane, 5'h0a, addr};
    endfunction

    // expected status view of one lane from the driven inputs and control state
    function automatic logic [31:0] status_word(input int lane);
        return {dmonitor_i[lane*16 +: 16], 5'b0, exp_lb[lane*3 +: 3], 3'b000, exp_eye[lane],
                high_ber_i[lane], block_lock_i[lane], qpll_lock_i, exp_gt};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_value("gt_reset_o", 32'(gt_reset_o), 32'(exp_gt));
        check_value("eye_reset_o", 32'(eye_reset_o), 32'(exp_eye));
        check_value("loopback_o", 32'(loopback_o), 32'(exp_lb));
    endtask

    // one classic cycle where an exp_lat of zero skips the latency check
    task automatic bus_access(input logic we, input logic [13:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, input logic exp_err, input int exp_lat,
                              output logic [31:0] rdat);
        int   cycles;
        logic ack;
        logic err;
        @(posedge wb_clk_i);
        #1;
        {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i, wb_sel_i} = {2'b11, we, adr, dat, sel};
        cycles = 0;
        ack = 1'b0;
        err = 1'b0;
        rdat = '0;
        while (!ack && !err && cycles < 200) begin
            @(posedge wb_clk_i);
            #1;
            cycles++;
            ack = wb_ack_o;
            err = wb_err_o;
            rdat = wb_dat_o;
        end
        if (!ack && !err) begin
            $display("no bus response at %0t ns for address %h", $time, adr);
            errors++;
        end else begin
            check_value("err flag", 32'(err), 32'(exp_err));
            if (exp_lat > 0) begin
                check_value("latency", cycles, exp_lat);
            end
            // request stays up across the edge where the master samples the response
            @(posedge wb_clk_i);
            #1;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic csr_write(input logic lane, input logic [2:0] lb, input logic eye,
                             input logic gt, input logic [3:0] sel);
        bus_access(1'b1, {11'h0, lane, 2'b00}, {21'h0, lb, 3'h0, eye, 3'h0, gt}, sel, 1'b0, 1, rd);
        if (sel[0]) begin
            exp_gt = gt;
            exp_eye[lane] = eye;
        end
        if (sel[1]) begin
            exp_lb[lane*3 +: 3] = lb;
        end
        check_outputs();
    endtask

    // data is written on a write and expected back on a read
    task automatic drp_access(input logic we, input logic lane, input logic [9:0] addr,
                              input logic [15:0] data, input logic exp_err);
        logic [15:0] wdat;
        // reads send the inverted word so a stray DRP write would show in the readback
        wdat = we ? data : ~data;
        bus_access(we, {1'b1, lane, addr, 2'b00}, {16'h0, wdat}, 4'hf, exp_err, 0, rd);
        if (!exp_err) begin
            check_value("drp lane", 32'(mdl_lane), 32'(lane));
            check_value("drp address", 32'(mdl_addr), 32'(addr));
            if (!we) begin
                check_value("drp read data", rd, {16'h0, data});
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed with %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        for (int l = 0; l < 2; l++) begin
            for (int a = 0; a < 1024; a++) begin
                drp_mem[l][a] = fill_value(l[0], a[9:0]);
            end
        end
        repeat (4) @(posedge wb_clk_i);
        #1;
        reset_i = 1'b0;

        check_outputs();
        for (int l = 0; l < 2; l++) begin
            bus_access(1'b0, {11'h0, l[0], 2'b00}, '0, 4'hf, 1'b0, 1, rd);
            check_value("control bits after reset", rd & 32'h0000_ff11, 32'h0);
        end
        end_test("reset values");

        csr_write(1'b0, 3'b101, 1'b1, 1'b1, 4'b0011);
        csr_write(1'b1, 3'b011, 1'b1, 1'b0, 4'b0011);
        // byte 1 masked off so loopback of lane 0 must stay at 101
        csr_write(1'b0, 3'b111, 1'b0, 1'b1, 4'b0001);
        end_test("control writes");

        qpll_lock_i = 1'b1;
        block_lock_i = 2'b10;
        high_ber_i = 2'b01;
        dmonitor_i = 32'hbeef_1234;
        for (int l = 0; l < 2; l++) begin
            bus_access(1'b0, {11'h0, l[0], 2'b00}, '0, 4'hf, 1'b0, 1, rd);
            check_value("status word", rd, status_word(l));
        end
        end_test("status reads");

        drp_access(1'b1, 1'b0, 10'h155, 16'ha5c3, 1'b0);
        drp_access(1'b1, 1'b1, 10'h155, 16'h5a3c, 1'b0);
        drp_access(1'b1, 1'b1, 10'h2aa, 16'h0f1e, 1'b0);
        drp_access(1'b0, 1'b0, 10'h155, 16'ha5c3, 1'b0);
        drp_access(1'b0, 1'b1, 10'h155, 16'h5a3c, 1'b0);
        drp_access(1'b0, 1'b1, 10'h2aa, 16'h0f1e, 1'b0);
        // lane 0 never saw the write to 2aa
        drp_access(1'b0, 1'b0, 10'h2aa, fill_value(1'b0, 10'h2aa), 1'b0);
        end_test("drp write and read");

        drp_silent = 1'b1;
        drp_access(1'b0, 1'b1, 10'h155, 16'h0, 1'b1);
        drp_silent = 1'b0;
        bus_access(1'b0, 14'h0000, '0, 4'hf, 1'b0, 1, rd);
        check_value("status after drp timeout", rd, status_word(0));
        end_test("drp timeout");

        $display("tests run: %0d, failed: %0d, value errors: %0d, protocol errors: %0d",
                 tests, failed, errors, sfp_ctrl_top_i.u_props.fail_count);
        if (errors == 0 && sfp_ctrl_top_i.u_props.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/sfp_ctrl_props.sv ====
`timescale 1ns/1ps

// bus and DRP protocol rules seen at the top level ports
module sfp_ctrl_props (
    input logic       wb_clk_i,
    input logic       reset_i,
    input logic       cyc_i,
    input logic       stb_i,
    input logic       ack_i,
    input logic       err_i,
    input logic [1:0] drp_en_i
);

    int unsigned fail_count = 0;

    ack_err_exclusive: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        !(ack_i && err_i))
        else begin $error("ack and err high together"); fail_count++; end

    // a response belongs to a live request
    resp_in_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (ack_i || err_i) |-> (cyc_i && stb_i))
        else begin $error("response without cyc and stb"); fail_count++; end

    resp_one_cycle: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (ack_i || err_i) |=> !(ack_i || err_i))
        else begin $error("response longer than one cycle"); fail_count++; end

    drp_en_onehot: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $onehot0(drp_en_i))
        else begin $error("both drp enables high"); fail_count++; end

    drp_en_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (drp_en_i != 2'b00) |=> (drp_en_i == 2'b00))
        else begin $error("drp enable wider than one cycle"); fail_count++; end

endmodule

bind sfp_ctrl_top sfp_ctrl_props u_props (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o),
    .err_i    (wb_err_o),
    .drp_en_i (drp_en_o)
);

// ==== src/sfp_ctrl_top.sv ====
`timescale 1ns/1ps
`include "sfp_cfg.svh"

module sfp_ctrl_top
    import sfp_pkg::*;
(
    input  logic                                  wb_clk_i,
    input  logic                                  reset_i,
    // wishbone classic slave
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [`SFP_WB_ADR_W-1:0]              wb_adr_i,
    input  logic [`SFP_WB_DAT_W-1:0]              wb_dat_i,
    input  logic [`SFP_WB_SEL_W-1:0]              wb_sel_i,
    output logic [`SFP_WB_DAT_W-1:0]              wb_dat_o,
    output logic                                  wb_ack_o,
    output logic                                  wb_err_o,
    // lane status, lane 0 in the low bits
    input  logic                                  qpll_lock_i,
    input  logic [`SFP_NLANE-1:0]                 block_lock_i,
    input  logic [`SFP_NLANE-1:0]                 high_ber_i,
    input  logic [`SFP_NLANE*`SFP_DRP_DAT_W-1:0]  dmonitor_i,
    // lane control
    output logic                                  gt_reset_o,
    output logic [`SFP_NLANE-1:0]                 eye_reset_o,
    output logic [`SFP_NLANE*3-1:0]               loopback_o,
    // DRP ports of both lanes
    output logic [`SFP_NLANE-1:0]                 drp_en_o,
    output logic                                  drp_we_o,
    output logic [`SFP_DRP_ADR_W-1:0]             drp_addr_o,
    output logic [`SFP_DRP_DAT_W-1:0]             drp_di_o,
    input  logic [`SFP_NLANE*`SFP_DRP_DAT_W-1:0]  drp_do_i,
    input  logic [`SFP_NLANE-1:0]                 drp_rdy_i
);

    lane_status_t [`SFP_NLANE-1:0] lane_status;

    wb_if csr_bus ();
    wb_if drp_bus ();

    for (genvar i = 0; i < `SFP_NLANE; i++) begin : g_lane
        assign lane_status[i] = '{
            block_lock: block_lock_i[i],
            high_ber:   high_ber_i[i],
            dmonitor:   dmonitor_i[i*`SFP_DRP_DAT_W +: `SFP_DRP_DAT_W]
        };
    end

    sfp_wb_router u_router (
        .cyc_i   (wb_cyc_i),
        .stb_i   (wb_stb_i),
        .we_i    (wb_we_i),
        .adr_i   (wb_adr_i),
        .dat_i   (wb_dat_i),
        .sel_i   (wb_sel_i),
        .dat_o   (wb_dat_o),
        .ack_o   (wb_ack_o),
        .err_o   (wb_err_o),
        .csr_bus (csr_bus.master),
        .drp_bus (drp_bus.master)
    );

    sfp_csr_regs u_csr (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .bus           (csr_bus.slave),
        .qpll_lock_i   (qpll_lock_i),
        .lane_status_i (lane_status),
        .gt_reset_o    (gt_reset_o),
        .eye_reset_o   (eye_reset_o),
        .loopback_o    (loopback_o)
    );

    drp_bridge u_drp (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .bus        (drp_bus.slave),
        .drp_en_o   (drp_en_o),
        .drp_we_o   (drp_we_o),
        .drp_addr_o (drp_addr_o),
        .drp_di_o   (drp_di_o),
        .drp_do_i   (drp_do_i),
        .drp_rdy_i  (drp_rdy_i)
    );

endmodule

// ==== src/drp_bridge.sv ====
`timescale 1ns/1ps
`include "sfp_cfg.svh"

module drp_bridge
    import sfp_pkg::*;
(
    input  logic                                  wb_clk_i,
    input  logic                                  reset_i,
    wb_if.slave                                   bus,
    output logic [`SFP_NLANE-1:0]                 drp_en_o,
    output logic                                  drp_we_o,
    output logic [`SFP_DRP_ADR_W-1:0]             drp_addr_o,
    output logic [`SFP_DRP_DAT_W-1:0]             drp_di_o,
    input  logic [`SFP_NLANE*`SFP_DRP_DAT_W-1:0]  drp_do_i,
    input  logic [`SFP_NLANE-1:0]                 drp_rdy_i
);

    localparam int CNT_W = $clog2(`SFP_DRP_TIMEOUT);

    drp_state_e               state;
    logic                     req;
    logic                     lane_q;
    logic [CNT_W-1:0]         wait_cnt;
    logic                     ack_q;
    logic                     err_q;
    logic [`SFP_WB_DAT_W-1:0] dat_q;

    assign req = bus.cyc && bus.stb;

    // control path: state, enable pulse, timeout, response strobes
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state    <= DRP_IDLE;
            drp_en_o <= '0;
            wait_cnt <= '0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            drp_en_o <= '0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            case (state)
                DRP_IDLE: begin
                    if (req) begin
                        drp_en_o[bus.adr[`SFP_DRP_LANE_BIT]] <= 1'b1;
                        wait_cnt <= '0;
                        state    <= DRP_WAIT;
                    end
                end
                DRP_WAIT: begin
                    if (drp_rdy_i[lane_q]) begin
                        ack_q <= 1'b1;
                        state <= DRP_RESP;
                    end else if (wait_cnt == CNT_W'(`SFP_DRP_TIMEOUT - 1)) begin
                        // lane never answered
                        err_q <= 1'b1;
                        state <= DRP_RESP;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                DRP_RESP: begin
                    // hold off until the master lets go of stb
                    if (!req) begin
                        state <= DRP_IDLE;
                    end
                end
                default: state <= DRP_IDLE;
            endcase
        end
    end

    // request fields are latched once and held through the access
    always_ff @(posedge wb_clk_i) begin
        if (state == DRP_IDLE && req) begin
            lane_q     <= bus.adr[`SFP_DRP_LANE_BIT];
            drp_we_o   <= bus.we;
            drp_addr_o <= bus.adr[`SFP_DRP_ADR_W+1:2];
            drp_di_o   <= bus.dat_w[`SFP_DRP_DAT_W-1:0];
        end
        if (state == DRP_WAIT && drp_rdy_i[lane_q]) begin
            dat_q <= {{(`SFP_WB_DAT_W - `SFP_DRP_DAT_W){1'b0}},
                      drp_do_i[lane_q*`SFP_DRP_DAT_W +: `SFP_DRP_DAT_W]};
        end
    end

    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.dat_r = dat_q;

endmodule

// ==== src/sfp_csr_regs.sv ====
`timescale 1ns/1ps
`include "sfp_cfg.svh"

module sfp_csr_regs
    import sfp_pkg::*;
(
    input  logic                                wb_clk_i,
    input  logic                                reset_i,
    wb_if.slave                                 bus,
    input  logic                                qpll_lock_i,
    input  lane_status_t [`SFP_NLANE-1:0]       lane_status_i,
    output logic                                gt_reset_o,
    output logic [`SFP_NLANE-1:0]               eye_reset_o,
    output logic [`SFP_NLANE-1:0][2:0]          loopback_o
);

    logic                     req;
    logic                     lane;
    logic                     ack_q;
    logic [`SFP_WB_DAT_W-1:0] dat_q;
    gbe_word_u                wr_word;
    gbe_word_u                rd_word;

    assign req  = bus.cyc && bus.stb;
    assign lane = bus.adr[`SFP_CSR_LANE_BIT];

    // incoming data seen through the control view
    assign wr_word = bus.dat_w;

    // status view of the addressed lane
    always_comb begin
        rd_word                   = '0;
        rd_word.status.gbe_reset  = gt_reset_o;
        rd_word.status.qpll_lock  = qpll_lock_i;
        rd_word.status.block_lock = lane_status_i[lane].block_lock;
        rd_word.status.high_ber   = lane_status_i[lane].high_ber;
        rd_word.status.eye_reset  = eye_reset_o[lane];
        rd_word.status.zero       = 3'b000;
        rd_word.status.loopback   = {5'b00000, loopback_o[lane]};
        rd_word.status.dmonitor   = lane_status_i[lane].dmonitor;
    end

    // single-cycle ack, the second sampled cycle of a held request is ignored
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q       <= 1'b0;
            gt_reset_o  <= 1'b0;
            eye_reset_o <= '0;
            loopback_o  <= '0;
        end else begin
            ack_q <= req && !ack_q;
            if (req && !ack_q && bus.we) begin
                // byte 0 holds the reset bits
                if (bus.sel[0]) begin
                    gt_reset_o        <= wr_word.ctrl.gbe_reset;
                    eye_reset_o[lane] <= wr_word.ctrl.eye_reset;
                end
                // byte 1 holds the loopback code
                if (bus.sel[1]) begin
                    loopback_o[lane] <= wr_word.ctrl.loopback;
                end
            end
        end
    end

    // read data lands together with ack
    always_ff @(posedge wb_clk_i) begin
        if (req && !ack_q && !bus.we) begin
            dat_q <= rd_word;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;
    // control space never faults
    assign bus.err   = 1'b0;

endmodule

// ==== src/sfp_wb_router.sv ====
`timescale 1ns/1ps
`include "sfp_cfg.svh"

module sfp_wb_router
    import sfp_pkg::*;
(
    input  logic                     cyc_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [`SFP_WB_ADR_W-1:0] adr_i,
    input  logic [`SFP_WB_DAT_W-1:0] dat_i,
    input  logic [`SFP_WB_SEL_W-1:0] sel_i,
    output logic [`SFP_WB_DAT_W-1:0] dat_o,
    output logic                     ack_o,
    output logic                     err_o,
    wb_if.master                     csr_bus,
    wb_if.master                     drp_bus
);

    wb_region_e region;

    // the single place the space bit is looked at
    assign region = wb_region_e'(adr_i[`SFP_DRP_SPACE_BIT]);

    // only the addressed region sees a live cycle
    assign csr_bus.cyc   = cyc_i && (region == REGION_CSR);
    assign csr_bus.stb   = stb_i && (region == REGION_CSR);
    assign csr_bus.we    = we_i;
    assign csr_bus.adr   = adr_i;
    assign csr_bus.dat_w = dat_i;
    assign csr_bus.sel   = sel_i;

    assign drp_bus.cyc   = cyc_i && (region == REGION_DRP);
    assign drp_bus.stb   = stb_i && (region == REGION_DRP);
    assign drp_bus.we    = we_i;
    assign drp_bus.adr   = adr_i;
    assign drp_bus.dat_w = dat_i;
    assign drp_bus.sel   = sel_i;

    // response mux follows the same decode
    always_comb begin
        case (region)
            REGION_DRP: begin
                dat_o = drp_bus.dat_r;
                ack_o = drp_bus.ack;
                err_o = drp_bus.err;
            end
            default: begin
                dat_o = csr_bus.dat_r;
                ack_o = csr_bus.ack;
                err_o = csr_bus.err;
            end
        endcase
    end

endmodule

// ==== src/wb_if.sv ====
`timescale 1ns/1ps
`include "sfp_cfg.svh"

// wishbone classic bundle between the router and the two regions
interface wb_if;

    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`SFP_WB_ADR_W-1:0] adr;
    logic [`SFP_WB_DAT_W-1:0] dat_w;
    logic [`SFP_WB_SEL_W-1:0] sel;
    logic [`SFP_WB_DAT_W-1:0] dat_r;
    logic                     ack;
    logic                     err;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err
    );

endinterface

// ==== src/sfp_pkg.sv ====
`include "sfp_cfg.svh"

package sfp_pkg;

    // lane control word as written by software
    typedef struct packed {
        logic [20:0] rsvd_hi;
        logic [2:0]  loopback;
        logic [2:0]  rsvd_mid;
        logic        eye_reset;
        logic [2:0]  rsvd_lo;
        logic        gbe_reset;
    } gbe_ctrl_t;

    // same address read back as status
    typedef struct packed {
        logic [15:0] dmonitor;
        logic [7:0]  loopback;
        logic [2:0]  zero;
        logic        eye_reset;
        logic        high_ber;
        logic        block_lock;
        logic        qpll_lock;
        logic        gbe_reset;
    } gbe_status_t;

    // one word, control view on write and status view on read
    typedef union packed {
        gbe_ctrl_t   ctrl;
        gbe_status_t status;
    } gbe_word_u;

    // per-lane status coming from the transceiver side
    typedef struct packed {
        logic                      block_lock;
        logic                      high_ber;
        logic [`SFP_DRP_DAT_W-1:0] dmonitor;
    } lane_status_t;

    // which half of the address space an access falls in
    typedef enum logic {REGION_CSR = 1'b0, REGION_DRP = 1'b1} wb_region_e;

    typedef enum logic [1:0] {DRP_IDLE, DRP_WAIT, DRP_RESP} drp_state_e;

endpackage

// ==== src/sfp_cfg.svh ====
`ifndef SFP_CFG_SVH
`define SFP_CFG_SVH

// wishbone slave geometry, byte addressed
`define SFP_WB_ADR_W 14
`define SFP_WB_DAT_W 32
`define SFP_WB_SEL_W 4

// upper half of the address space goes to the DRP ports
`define SFP_DRP_SPACE_BIT 13
// lane select inside each half
`define SFP_DRP_LANE_BIT 12
`define SFP_CSR_LANE_BIT 2

// transceiver DRP port, address comes from byte address bits 11:2
`define SFP_DRP_ADR_W 10
`define SFP_DRP_DAT_W 16

`define SFP_NLANE 2
// cycles to wait for drp_rdy before the access ends in err
`define SFP_DRP_TIMEOUT 64

`endif
